// ==== hw/cvxif_pkg.sv ====
// Extension interface widths
package cvxif_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Instruction id carried on issue, commit and result
  localparam int unsigned X_ID_WIDTH = 4;

  // Destination register index
  localparam int unsigned X_RD_WIDTH = 5;

  // Issue queue size
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_PTR_WIDTH = 3;

  // Free-running delay counter that paces results
  localparam int unsigned DELAY_WIDTH = 4;

endpackage

// ==== hw/cvxif_instr_pkg.sv ====
// Custom instruction encodings
package cvxif_instr_pkg;

  // Major opcode shared by all coprocessor instructions
  localparam logic [6:0] OPCODE_CUSTOM3 = 7'h7B;

  // Instruction selection inside custom-3
  localparam logic [2:0] FUNCT3_ADD      = 3'b000;
  localparam logic [2:0] FUNCT3_ADD3     = 3'b001;
  localparam logic [2:0] FUNCT3_ADD_NOWB = 3'b010;

  // Operation carried from decode to the result unit
  typedef enum logic [1:0] {
    OP_ADD      = 2'd0,
    OP_ADD3     = 2'd1,
    OP_ADD_NOWB = 2'd2
  } copro_op_e;

endpackage

// ==== hw/instr_decoder.sv ====
// Custom instruction decoder
`timescale 1ns/1ps

module instr_decoder (
  input  logic                       issue_valid_i,
  input  logic [31:0]                issue_instr_i,
  output logic                       accept_o,
  output logic                       writeback_o,
  output cvxif_instr_pkg::copro_op_e op_o
);

  import cvxif_instr_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];

  always_comb begin
    accept_o    = 1'b0;
    writeback_o = 1'b0;
    op_o        = OP_ADD;

    // Only respond to a real offer under custom-3
    if (issue_valid_i && (opcode == OPCODE_CUSTOM3)) begin
      case (funct3)
        FUNCT3_ADD: begin
          accept_o    = 1'b1;
          writeback_o = 1'b1;
          op_o        = OP_ADD;
        end
        FUNCT3_ADD3: begin
          accept_o    = 1'b1;
          writeback_o = 1'b1;
          op_o        = OP_ADD3;
        end
        FUNCT3_ADD_NOWB: begin
          // Sum is still produced, the core just does not write it
          accept_o    = 1'b1;
          writeback_o = 1'b0;
          op_o        = OP_ADD_NOWB;
        end
        default: begin
          accept_o    = 1'b0;
          writeback_o = 1'b0;
          op_o        = OP_ADD;
        end
      endcase
    end
  end

endmodule

// ==== hw/issue_fifo.sv ====
// Fall-through issue queue
`timescale 1ns/1ps

module issue_fifo (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                clear_i,
  input  logic                                push_i,
  input  logic                                pop_i,
  input  logic [cvxif_pkg::X_ID_WIDTH-1:0]    id_i,
  input  logic [cvxif_pkg::XLEN-1:0]          rs1_i,
  input  logic [cvxif_pkg::XLEN-1:0]          rs2_i,
  input  logic [cvxif_pkg::XLEN-1:0]          rs3_i,
  input  logic [cvxif_pkg::X_RD_WIDTH-1:0]    rd_i,
  input  cvxif_instr_pkg::copro_op_e          op_i,
  input  logic                                wb_i,
  output logic [cvxif_pkg::X_ID_WIDTH-1:0]    id_o,
  output logic [cvxif_pkg::XLEN-1:0]          rs1_o,
  output logic [cvxif_pkg::XLEN-1:0]          rs2_o,
  output logic [cvxif_pkg::XLEN-1:0]          rs3_o,
  output logic [cvxif_pkg::X_RD_WIDTH-1:0]    rd_o,
  output cvxif_instr_pkg::copro_op_e          op_o,
  output logic                                wb_o,
  output logic                                empty_o,
  output logic                                ready_o
);

  import cvxif_pkg::*;
  import cvxif_instr_pkg::*;

  localparam logic [FIFO_PTR_WIDTH:0] DEPTH_CNT = (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH);

  logic [X_ID_WIDTH-1:0]     id_mem  [FIFO_DEPTH];
  logic [XLEN-1:0]           rs1_mem [FIFO_DEPTH];
  logic [XLEN-1:0]           rs2_mem [FIFO_DEPTH];
  logic [XLEN-1:0]           rs3_mem [FIFO_DEPTH];
  logic [X_RD_WIDTH-1:0]     rd_mem  [FIFO_DEPTH];
  copro_op_e                 op_mem  [FIFO_DEPTH];
  logic                      wb_mem  [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
  logic [FIFO_PTR_WIDTH:0]   count_q;
  logic [FIFO_PTR_WIDTH:0]   count_d;
  logic                      ready_q;
  logic                      buf_empty;
  logic                      full;
  logic                      push_en;
  logic                      pop_en;

  assign buf_empty = (count_q == '0);
  assign full      = (count_q == DEPTH_CNT);
  assign push_en   = push_i & ~full;
  // An empty queue can still pop the entry that falls through
  assign pop_en    = pop_i & (~buf_empty | push_en);

  always_comb begin
    count_d = count_q;
    if (push_en && !pop_en) begin
      count_d = count_q + 1'b1;
    end else if (!push_en && pop_en) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b1;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b1;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // Look ahead one cycle so an accepted push always finds room
      ready_q <= (count_d < DEPTH_CNT);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      id_mem[wr_ptr_q]  <= id_i;
      rs1_mem[wr_ptr_q] <= rs1_i;
      rs2_mem[wr_ptr_q] <= rs2_i;
      rs3_mem[wr_ptr_q] <= rs3_i;
      rd_mem[wr_ptr_q]  <= rd_i;
      op_mem[wr_ptr_q]  <= op_i;
      wb_mem[wr_ptr_q]  <= wb_i;
    end
  end

  // Head comes straight from the push side while the buffer is empty
  always_comb begin
    if (buf_empty) begin
      id_o  = id_i;
      rs1_o = rs1_i;
      rs2_o = rs2_i;
      rs3_o = rs3_i;
      rd_o  = rd_i;
      op_o  = op_i;
      wb_o  = wb_i;
    end else begin
      id_o  = id_mem[rd_ptr_q];
      rs1_o = rs1_mem[rd_ptr_q];
      rs2_o = rs2_mem[rd_ptr_q];
      rs3_o = rs3_mem[rd_ptr_q];
      rd_o  = rd_mem[rd_ptr_q];
      op_o  = op_mem[rd_ptr_q];
      wb_o  = wb_mem[rd_ptr_q];
    end
  end

  assign empty_o = buf_empty & ~push_en;
  assign ready_o = ready_q;

endmodule

// ==== hw/result_unit.sv ====
// Result computation and offer
`timescale 1ns/1ps

module result_unit (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              clear_i,
  input  logic                              head_valid_i,
  input  logic [cvxif_pkg::X_ID_WIDTH-1:0]  head_id_i,
  input  logic [cvxif_pkg::XLEN-1:0]        head_rs1_i,
  input  logic [cvxif_pkg::XLEN-1:0]        head_rs2_i,
  input  logic [cvxif_pkg::XLEN-1:0]        head_rs3_i,
  input  logic [cvxif_pkg::X_RD_WIDTH-1:0]  head_rd_i,
  input  cvxif_instr_pkg::copro_op_e        head_op_i,
  input  logic                              head_wb_i,
  input  logic                              commit_valid_i,
  input  logic                              commit_kill_i,
  input  logic                              result_ready_i,
  output logic                              pop_o,
  output logic                              result_valid_o,
  output logic [cvxif_pkg::X_ID_WIDTH-1:0]  result_id_o,
  output logic [cvxif_pkg::XLEN-1:0]        result_data_o,
  output logic [cvxif_pkg::X_RD_WIDTH-1:0]  result_rd_o,
  output logic                              result_we_o
);

  import cvxif_pkg::*;
  import cvxif_instr_pkg::*;

  typedef enum logic {
    WAIT,
    OFFER
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  logic [XLEN-1:0]        sum;
  logic [DELAY_WIDTH-1:0] delay_q;
  logic                   kill;
  logic                   match;
  logic                   delivered;
  logic [X_ID_WIDTH-1:0]  id_q;
  logic [XLEN-1:0]        data_q;
  logic [X_RD_WIDTH-1:0]  rd_q;
  logic                   we_q;

  assign kill      = commit_valid_i & commit_kill_i;
  assign sum       = head_rs1_i + head_rs2_i + ((head_op_i == OP_ADD3) ? head_rs3_i : '0);
  assign match     = head_valid_i & (delay_q == sum[DELAY_WIDTH-1:0]);
  assign delivered = (state_q == OFFER) & result_ready_i;

  // One pop per cycle, a kill and a delivery both retire the head
  assign pop_o = kill | delivered;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WAIT: begin
        if (match && !kill) begin
          state_d = OFFER;
        end
      end
      OFFER: begin
        if (kill || result_ready_i) begin
          state_d = WAIT;
        end
      end
      default: state_d = WAIT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= WAIT;
      delay_q <= '0;
    end else if (clear_i) begin
      state_q <= WAIT;
      delay_q <= '0;
    end else begin
      state_q <= state_d;
      // A committed instruction restarts the delay
      if (commit_valid_i && !commit_kill_i) begin
        delay_q <= '0;
      end else begin
        delay_q <= delay_q + 1'b1;
      end
    end
  end

  // Offer fields are captured once and held until taken
  always_ff @(posedge clk_i) begin
    if ((state_q == WAIT) && match) begin
      id_q   <= head_id_i;
      data_q <= sum;
      rd_q   <= head_rd_i;
      we_q   <= head_wb_i;
    end
  end

  assign result_valid_o = (state_q == OFFER);
  assign result_id_o    = id_q;
  assign result_data_o  = data_q;
  assign result_rd_o    = rd_q;
  assign result_we_o    = we_q;

endmodule

// ==== hw/cvxif_coprocessor.sv ====
// Example extension coprocessor
`timescale 1ns/1ps

module cvxif_coprocessor (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              clear_i,
  // Issue channel
  input  logic                              issue_valid_i,
  input  logic [31:0]                       issue_instr_i,
  input  logic [cvxif_pkg::X_ID_WIDTH-1:0]  issue_id_i,
  input  logic [cvxif_pkg::XLEN-1:0]        issue_rs1_i,
  input  logic [cvxif_pkg::XLEN-1:0]        issue_rs2_i,
  input  logic [cvxif_pkg::XLEN-1:0]        issue_rs3_i,
  output logic                              issue_ready_o,
  output logic                              issue_accept_o,
  output logic                              issue_writeback_o,
  // Commit channel
  input  logic                              commit_valid_i,
  input  logic [cvxif_pkg::X_ID_WIDTH-1:0]  commit_id_i,
  input  logic                              commit_kill_i,
  // Result channel
  output logic                              result_valid_o,
  input  logic                              result_ready_i,
  output logic [cvxif_pkg::X_ID_WIDTH-1:0]  result_id_o,
  output logic [cvxif_pkg::XLEN-1:0]        result_data_o,
  output logic [cvxif_pkg::X_RD_WIDTH-1:0]  result_rd_o,
  output logic                              result_we_o
);

  import cvxif_pkg::*;
  import cvxif_instr_pkg::*;

  logic                  dec_accept;
  logic                  dec_writeback;
  copro_op_e             dec_op;
  logic                  push;
  logic                  pop;
  logic                  fifo_empty;
  logic [X_RD_WIDTH-1:0] issue_rd;
  logic [X_ID_WIDTH-1:0] head_id;
  logic [XLEN-1:0]       head_rs1;
  logic [XLEN-1:0]       head_rs2;
  logic [XLEN-1:0]       head_rs3;
  logic [X_RD_WIDTH-1:0] head_rd;
  copro_op_e             head_op;
  logic                  head_wb;
  logic                  commit_kill_head;

  instr_decoder u_decoder (
    .issue_valid_i (issue_valid_i),
    .issue_instr_i (issue_instr_i),
    .accept_o      (dec_accept),
    .writeback_o   (dec_writeback),
    .op_o          (dec_op)
  );

  assign issue_accept_o    = dec_accept;
  assign issue_writeback_o = dec_writeback;

  // Rejected offers are taken and dropped, only accepted ones are queued
  assign push     = issue_valid_i & issue_ready_o & dec_accept;
  assign issue_rd = issue_instr_i[11:7];

  issue_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (clear_i),
    .push_i  (push),
    .pop_i   (pop),
    .id_i    (issue_id_i),
    .rs1_i   (issue_rs1_i),
    .rs2_i   (issue_rs2_i),
    .rs3_i   (issue_rs3_i),
    .rd_i    (issue_rd),
    .op_i    (dec_op),
    .wb_i    (dec_writeback),
    .id_o    (head_id),
    .rs1_o   (head_rs1),
    .rs2_o   (head_rs2),
    .rs3_o   (head_rs3),
    .rd_o    (head_rd),
    .op_o    (head_op),
    .wb_o    (head_wb),
    .empty_o (fifo_empty),
    .ready_o (issue_ready_o)
  );

  // Commits always target the head, a kill must name its id
  assign commit_kill_head = commit_kill_i & (commit_id_i == head_id);

  result_unit u_result (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear_i),
    .head_valid_i   (~fifo_empty),
    .head_id_i      (head_id),
    .head_rs1_i     (head_rs1),
    .head_rs2_i     (head_rs2),
    .head_rs3_i     (head_rs3),
    .head_rd_i      (head_rd),
    .head_op_i      (head_op),
    .head_wb_i      (head_wb),
    .commit_valid_i (commit_valid_i),
    .commit_kill_i  (commit_kill_head),
    .result_ready_i (result_ready_i),
    .pop_o          (pop),
    .result_valid_o (result_valid_o),
    .result_id_o    (result_id_o),
    .result_data_o  (result_data_o),
    .result_rd_o    (result_rd_o),
    .result_we_o    (result_we_o)
  );

endmodule

// ==== testbench/cvxif_coprocessor_sva.sv ====
// Coprocessor handshake assertions
`timescale 1ns/1ps

module cvxif_coprocessor_sva (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              issue_valid_i,
  input logic                              issue_accept_o,
  input logic                              result_valid_o,
  input logic                              result_ready_i,
  input logic [cvxif_pkg::X_ID_WIDTH-1:0]  result_id_o,
  input logic [cvxif_pkg::XLEN-1:0]        result_data_o,
  input logic [cvxif_pkg::X_RD_WIDTH-1:0]  result_rd_o,
  input logic                              result_we_o
);

  // Held offer keeps its fields until taken or dropped
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (result_valid_o && !result_ready_i) |=>
      (!result_valid_o || $stable({result_id_o, result_data_o, result_rd_o, result_we_o})))
    else $error("result fields changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_accept_o |-> issue_valid_i)
    else $error("issue accept without a valid offer");

  // First sampled cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !result_valid_o)
    else $error("result valid right after reset");

endmodule

bind cvxif_coprocessor cvxif_coprocessor_sva u_sva (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .issue_valid_i  (issue_valid_i),
  .issue_accept_o (issue_accept_o),
  .result_valid_o (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_id_o    (result_id_o),
  .result_data_o  (result_data_o),
  .result_rd_o    (result_rd_o),
  .result_we_o    (result_we_o)
);

// ==== testbench/tb_cvxif_coprocessor.sv ====
// Coprocessor testbench
`timescale 1ns/1ps

module tb_cvxif_coprocessor;

  import cvxif_pkg::*;
  import cvxif_instr_pkg::*;

  localparam int          NUM_TXN     = 300;
  localparam int          CYCLE_LIMIT = 40 * NUM_TXN;
  localparam logic [31:0] SEED        = 32'h06df_a4cb;

  localparam int MODE_RANDOM = 0;
  localparam int MODE_FILL   = 1;
  localparam int MODE_IDLE   = 2;
  localparam int MODE_CLEAR  = 3;

  logic                  clk;
  logic                  rst_n;
  logic                  clear;
  logic                  issue_valid;
  logic [31:0]           issue_instr;
  logic [X_ID_WIDTH-1:0] issue_id;
  logic [XLEN-1:0]       issue_rs1;
  logic [XLEN-1:0]       issue_rs2;
  logic [XLEN-1:0]       issue_rs3;
  logic                  issue_ready;
  logic                  issue_accept;
  logic                  issue_writeback;
  logic                  commit_valid;
  logic [X_ID_WIDTH-1:0] commit_id;
  logic                  commit_kill;
  logic                  result_valid;
  logic                  result_ready;
  logic [X_ID_WIDTH-1:0] result_id;
  logic [XLEN-1:0]       result_data;
  logic [X_RD_WIDTH-1:0] result_rd;
  logic                  result_we;

  // Reference model of queued instructions, oldest first
  logic [31:0] exp_data[$];
  logic [31:0] exp_id[$];
  logic [31:0] exp_rd[$];
  logic [31:0] exp_we[$];

  logic [31:0] lfsr;
  logic        ready_hold;
  logic        held_valid;
  logic [31:0] held_id;
  logic [31:0] held_data;
  logic [31:0] held_rd;
  logic [31:0] held_we;
  int          error_count;
  int          check_count;
  int          accept_count;
  int          cycle_count;

  cvxif_coprocessor uut (
    .clk_i(clk), .rst_n_i(rst_n), .clear_i(clear),
    .issue_valid_i(issue_valid), .issue_instr_i(issue_instr), .issue_id_i(issue_id),
    .issue_rs1_i(issue_rs1), .issue_rs2_i(issue_rs2), .issue_rs3_i(issue_rs3),
    .issue_ready_o(issue_ready), .issue_accept_o(issue_accept),
    .issue_writeback_o(issue_writeback),
    .commit_valid_i(commit_valid), .commit_id_i(commit_id), .commit_kill_i(commit_kill),
    .result_valid_o(result_valid), .result_ready_i(result_ready),
    .result_id_o(result_id), .result_data_o(result_data),
    .result_rd_o(result_rd), .result_we_o(result_we)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] make_instr(input logic force_legal);
    logic [31:0] instr;
    logic [2:0]  f3;
    instr = rand_bits(32);
    if (force_legal || (rand_bits(2) != 0)) begin
      f3 = 3'(rand_bits(2));
      if (force_legal && (f3 == 3'd3)) begin
        f3 = FUNCT3_ADD3;
      end
      instr[6:0]   = OPCODE_CUSTOM3;
      instr[14:12] = f3;
    end
    return instr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic drive_issue(input logic force_legal);
    issue_valid <= force_legal ? 1'b1 : 1'(rand_bits(1));
    issue_instr <= make_instr(force_legal);
    issue_id    <= X_ID_WIDTH'(rand_bits(X_ID_WIDTH));
    issue_rs1   <= rand_bits(32);
    issue_rs2   <= rand_bits(32);
    issue_rs3   <= rand_bits(32);
  endtask

  task automatic drive_inputs(input int mode);
    logic [31:0] r;
    clear        <= 1'b0;
    issue_valid  <= 1'b0;
    commit_valid <= 1'b0;
    commit_kill  <= 1'b0;
    result_ready <= 1'b0;
    case (mode)
      MODE_RANDOM: begin
        if (rand_bits(6) == 0) begin
          clear <= 1'b1;
        end else begin
          drive_issue(1'b0);
          if (rand_bits(2) == 0) begin
            ready_hold = ~ready_hold;
          end
          r = rand_bits(3);
          // Kill only the oldest, never in the same cycle as a delivery
          if ((r == 0) && (exp_id.size() != 0)) begin
            commit_valid <= 1'b1;
            commit_kill  <= 1'b1;
            commit_id    <= X_ID_WIDTH'(exp_id[0]);
          end else begin
            if (r == 1) begin
              commit_valid <= 1'b1;
              commit_id    <= X_ID_WIDTH'(rand_bits(X_ID_WIDTH));
            end
            result_ready <= ready_hold;
          end
        end
      end
      MODE_FILL: drive_issue(1'b1);
      MODE_IDLE: result_ready <= 1'b1;
      MODE_CLEAR: clear <= 1'b1;
      default: result_ready <= 1'b0;
    endcase
  endtask

  task automatic monitor_cycle();
    logic [2:0]  f3;
    logic        exp_acc;
    logic        exp_wb;
    logic        kill_seen;
    logic [31:0] sum;
    f3      = issue_instr[14:12];
    exp_acc = issue_valid && (issue_instr[6:0] == OPCODE_CUSTOM3) &&
              ((f3 == FUNCT3_ADD) || (f3 == FUNCT3_ADD3) || (f3 == FUNCT3_ADD_NOWB));
    exp_wb  = exp_acc && (f3 != FUNCT3_ADD_NOWB);
    check_value("issue_accept_o", 32'(issue_accept), 32'(exp_acc));
    check_value("issue_writeback_o", 32'(issue_writeback), 32'(exp_wb));
    // Offer must not move while the core holds it off
    if (held_valid && result_valid) begin
      check_value("result_id_o", 32'(result_id), held_id);
      check_value("result_data_o", result_data, held_data);
      check_value("result_rd_o", 32'(result_rd), held_rd);
      check_value("result_we_o", 32'(result_we), held_we);
    end
    if (result_valid && result_ready) begin
      if (exp_data.size() == 0) begin
        error_count++;
        $display("A result was delivered while no instruction was outstanding");
      end else begin
        check_value("result_id_o", 32'(result_id), exp_id.pop_front());
        check_value("result_data_o", result_data, exp_data.pop_front());
        check_value("result_rd_o", 32'(result_rd), exp_rd.pop_front());
        check_value("result_we_o", 32'(result_we), exp_we.pop_front());
      end
    end
    kill_seen = commit_valid && commit_kill;
    if (kill_seen && (exp_data.size() != 0)) begin
      void'(exp_id.pop_front());
      void'(exp_data.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_we.pop_front());
    end
    held_valid = result_valid && !result_ready && !kill_seen && !clear;
    held_id    = 32'(result_id);
    held_data  = result_data;
    held_rd    = 32'(result_rd);
    held_we    = 32'(result_we);
    if (issue_valid && issue_ready && exp_acc) begin
      accept_count++;
      sum = issue_rs1 + issue_rs2;
      if (f3 == FUNCT3_ADD3) begin
        sum = sum + issue_rs3;
      end
      exp_id.push_back(32'(issue_id));
      exp_data.push_back(sum);
      exp_rd.push_back(32'(issue_instr[11:7]));
      exp_we.push_back(32'(exp_wb));
    end
    if (clear) begin
      exp_id.delete();
      exp_data.delete();
      exp_rd.delete();
      exp_we.delete();
    end
  endtask

  task automatic step(input int mode);
    @(posedge clk);
    drive_inputs(mode);
    @(negedge clk);
    monitor_cycle();
  endtask

  task automatic drain();
    while (exp_data.size() != 0) begin
      step(MODE_IDLE);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    clear        = 1'b0;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_id     = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_rs3    = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    commit_kill  = 1'b0;
    result_ready = 1'b0;
    lfsr         = SEED;
    ready_hold   = 1'b1;
    held_valid   = 1'b0;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_TXN; i++) begin
      step(MODE_RANDOM);
    end
    drain();

    // Fill the queue with no commits and the result port stalled
    accept_count = 0;
    step(MODE_FILL);
    while (issue_ready) begin
      step(MODE_FILL);
    end
    check_value("accepts_before_full", 32'(accept_count), 32'(FIFO_DEPTH));
    drain();

    // Flush a full queue while a result is held on the port
    step(MODE_FILL);
    while (issue_ready) begin
      step(MODE_FILL);
    end
    while (!result_valid) begin
      step(MODE_FILL);
    end
    step(MODE_CLEAR);
    step(MODE_IDLE);
    check_value("result_valid_o", 32'(result_valid), 32'd0);
    check_value("issue_ready_o", 32'(issue_ready), 32'd1);
    repeat (40) step(MODE_IDLE);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/cvxif_pkg.sv
hw/cvxif_instr_pkg.sv
hw/instr_decoder.sv
hw/issue_fifo.sv
hw/result_unit.sv
hw/cvxif_coprocessor.sv
testbench/cvxif_coprocessor_sva.sv
testbench/tb_cvxif_coprocessor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=tb_cvxif_coprocessor

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$OBJ_DIR" -o sim_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
exit 1
